// File: Makefile
# Verilator flow for the CDC FIFO testbench
TOP := cdc_fifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f sim.f --top-module $(TOP)

# The run passes only if the log holds the pass line
sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: logic/cdc_cfg_pkg.sv
// Credit configuration register map
package cdc_cfg_pkg;

  // --------------------
  // Types
  // --------------------

  // Credit values run from 0 to DEPTH, same width as a pointer
  typedef logic [cdc_fifo_pkg::ADDR_W:0] credit_t;

  // Register address space has room for four registers
  typedef logic [1:0] cfg_addr_t;

  // --------------------
  // Register map
  // --------------------

  // Number of credits held back from the sender
  localparam cfg_addr_t CFG_ADDR_WITHHOLD = 2'd0;
  // Bit 0 lets credits flow at all
  localparam cfg_addr_t CFG_ADDR_ENABLE = 2'd1;

  // Current configuration as seen by the push controller
  typedef struct packed {
    credit_t withhold;
    logic    enable;
  } credit_cfg_t;

endpackage

// File: logic/cdc_fifo_pkg.sv
// CDC FIFO geometry and types
package cdc_fifo_pkg;

  // --------------------
  // Geometry
  // --------------------

  // Number of entries, must stay a power of two for the pointer math
  localparam int DEPTH = 8;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int DATA_W = 16;
  // Flop stages in each pointer synchronizer
  localparam int NUM_SYNC_STAGES = 3;

  // --------------------
  // Types
  // --------------------

  typedef logic [ADDR_W-1:0] addr_t;
  // Extra top bit tells a full FIFO apart from an empty one
  typedef logic [ADDR_W:0] ptr_t;
  typedef logic [DATA_W-1:0] data_t;
  // Holds 0 to DEPTH inclusive
  typedef logic [ADDR_W:0] count_t;

  // One RAM write request
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } ram_wr_t;

  // Binary to Gray, adjacent values differ in one bit
  function automatic ptr_t bin2gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray back to binary, each bit folds in all bits above it
  function automatic ptr_t gray2bin(ptr_t gray);
    ptr_t bin;
    bin[ADDR_W] = gray[ADDR_W];
    for (int i = ADDR_W - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: logic/cdc_fifo_top.sv
// Credit push CDC FIFO top level
`timescale 1ns/100ps

module cdc_fifo_top (
  input  logic                   push_clk,
  input  logic                   pop_clk,
  input  logic                   rst_n,
  // Push side, credit and valid
  input  logic                   push_valid,
  input  cdc_fifo_pkg::data_t    push_data,
  input  logic                   push_credit_stall,
  output logic                   push_credit,
  output logic                   push_full,
  output cdc_fifo_pkg::count_t   push_slots,
  output cdc_cfg_pkg::credit_t   credit_count,
  output cdc_cfg_pkg::credit_t   credit_available,
  // Configuration writes, push clock
  input  logic                   cfg_wr,
  input  cdc_cfg_pkg::cfg_addr_t cfg_addr,
  input  cdc_cfg_pkg::credit_t   cfg_wdata,
  // Pop side, ready and valid
  input  logic                   pop_ready,
  output logic                   pop_valid,
  output cdc_fifo_pkg::data_t    pop_data,
  output logic                   pop_empty,
  output cdc_fifo_pkg::count_t   pop_items
);

  cdc_cfg_pkg::credit_cfg_t cfg;
  cdc_fifo_pkg::ram_wr_t    ram_wr;
  cdc_fifo_pkg::ptr_t       wr_ptr_gray;
  cdc_fifo_pkg::ptr_t       wr_ptr_gray_sync;
  cdc_fifo_pkg::ptr_t       rd_ptr_gray;
  cdc_fifo_pkg::ptr_t       rd_ptr_gray_sync;
  logic                     rd_en;
  cdc_fifo_pkg::addr_t      rd_addr;
  cdc_fifo_pkg::data_t      rd_data;

  // --------------------
  // Push domain
  // --------------------

  credit_cfg_regs credit_cfg_regs_i (
    .push_clk, .rst_n, .cfg_wr, .cfg_addr, .cfg_wdata, .cfg
  );

  fifo_push_ctrl fifo_push_ctrl_i (
    .push_clk, .rst_n, .push_valid, .push_data, .push_credit_stall, .cfg,
    .rd_ptr_gray_sync, .wr_ptr_gray, .ram_wr, .push_credit, .credit_count,
    .credit_available, .push_full, .push_slots
  );

  // --------------------
  // Crossings and storage
  // --------------------

  // Write pointer into the pop domain
  gray_sync wr_ptr_sync_i (
    .clk(pop_clk), .rst_n, .gray_in(wr_ptr_gray), .gray_out(wr_ptr_gray_sync)
  );

  // Read pointer back into the push domain
  gray_sync rd_ptr_sync_i (
    .clk(push_clk), .rst_n, .gray_in(rd_ptr_gray), .gray_out(rd_ptr_gray_sync)
  );

  flop_ram flop_ram_i (
    .push_clk, .pop_clk, .wr(ram_wr), .rd_en, .rd_addr, .rd_data
  );

  // Pop domain
  fifo_pop_ctrl fifo_pop_ctrl_i (
    .pop_clk, .rst_n, .pop_ready, .wr_ptr_gray_sync, .rd_data, .rd_en, .rd_addr,
    .rd_ptr_gray, .pop_valid, .pop_data, .pop_empty, .pop_items
  );

endmodule

// File: logic/credit_cfg_regs.sv
// Credit configuration registers
`timescale 1ns/100ps

module credit_cfg_regs (
  input  logic                      push_clk,
  input  logic                      rst_n,
  input  logic                      cfg_wr,
  input  cdc_cfg_pkg::cfg_addr_t    cfg_addr,
  input  cdc_cfg_pkg::credit_t      cfg_wdata,
  output cdc_cfg_pkg::credit_cfg_t  cfg
);

  // --------------------
  // Register writes
  // --------------------

  // A strobe updates one field, the new value is visible to the push
  // controller from the following cycle on
  always_ff @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      // Credits stay off and nothing is withheld until software says so
      cfg <= '0;
    end else if (cfg_wr) begin
      case (cfg_addr)
        cdc_cfg_pkg::CFG_ADDR_WITHHOLD: begin
          cfg.withhold <= cfg_wdata;
        end
        cdc_cfg_pkg::CFG_ADDR_ENABLE: begin
          // Only bit 0 carries meaning here
          cfg.enable <= cfg_wdata[0];
        end
        default: begin
          // Unmapped addresses are ignored
        end
      endcase
    end
  end

endmodule

// File: logic/fifo_pop_ctrl.sv
// FIFO pop side controller
`timescale 1ns/100ps

module fifo_pop_ctrl (
  input  logic                 pop_clk,
  input  logic                 rst_n,
  input  logic                 pop_ready,
  input  cdc_fifo_pkg::ptr_t   wr_ptr_gray_sync,
  input  cdc_fifo_pkg::data_t  rd_data,
  output logic                 rd_en,
  output cdc_fifo_pkg::addr_t  rd_addr,
  output cdc_fifo_pkg::ptr_t   rd_ptr_gray,
  output logic                 pop_valid,
  output cdc_fifo_pkg::data_t  pop_data,
  output logic                 pop_empty,
  output cdc_fifo_pkg::count_t pop_items
);

  cdc_fifo_pkg::ptr_t rd_ptr;
  cdc_fifo_pkg::ptr_t rd_ptr_next;
  cdc_fifo_pkg::ptr_t wr_ptr_q;

  // --------------------
  // Write pointer tracking
  // --------------------

  // Decoded write pointer gets one more flop before it is trusted
  always_ff @(posedge pop_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
    end else begin
      wr_ptr_q <= cdc_fifo_pkg::gray2bin(wr_ptr_gray_sync);
    end
  end

  // Items counted in RAM only, the word on the output is not included
  assign pop_items = wr_ptr_q - rd_ptr;
  assign pop_empty = (pop_items == '0);

  // --------------------
  // RAM read issue
  // --------------------

  // Read when there is a word and the output is free or leaving this cycle
  assign rd_en   = !pop_empty && (!pop_valid || pop_ready);
  assign rd_addr = rd_ptr[cdc_fifo_pkg::ADDR_W-1:0];

  assign rd_ptr_next = rd_ptr + cdc_fifo_pkg::ptr_t'(rd_en);

  // The slot is handed back to the push side once its word sits in the
  // RAM read register
  always_ff @(posedge pop_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_next;
      rd_ptr_gray <= cdc_fifo_pkg::bin2gray(rd_ptr_next);
    end
  end

  // --------------------
  // Output stage
  // --------------------

  // Valid is set by a read and held until the consumer takes the word
  always_ff @(posedge pop_clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_valid <= 1'b0;
    end else begin
      pop_valid <= rd_en || (pop_valid && !pop_ready);
    end
  end

  // RAM read register only loads on rd_en, so the word holds under stall
  assign pop_data = rd_data;

endmodule

// File: logic/fifo_push_ctrl.sv
// FIFO push side controller
`timescale 1ns/100ps

module fifo_push_ctrl (
  input  logic                      push_clk,
  input  logic                      rst_n,
  input  logic                      push_valid,
  input  cdc_fifo_pkg::data_t       push_data,
  input  logic                      push_credit_stall,
  input  cdc_cfg_pkg::credit_cfg_t  cfg,
  input  cdc_fifo_pkg::ptr_t        rd_ptr_gray_sync,
  output cdc_fifo_pkg::ptr_t        wr_ptr_gray,
  output cdc_fifo_pkg::ram_wr_t     ram_wr,
  output logic                      push_credit,
  output cdc_cfg_pkg::credit_t      credit_count,
  output cdc_cfg_pkg::credit_t      credit_available,
  output logic                      push_full,
  output cdc_fifo_pkg::count_t      push_slots
);

  cdc_fifo_pkg::ptr_t wr_ptr;
  cdc_fifo_pkg::ptr_t wr_ptr_next;
  cdc_fifo_pkg::ptr_t rd_ptr_bin;
  cdc_fifo_pkg::ptr_t rd_ptr_q;
  cdc_fifo_pkg::ptr_t rd_advance;
  cdc_fifo_pkg::ptr_t occupancy;

  // --------------------
  // Write path
  // --------------------

  // The sender only pushes with a credit in hand, so no full check here
  assign wr_ptr_next = wr_ptr + cdc_fifo_pkg::ptr_t'(push_valid);

  always_comb begin
    ram_wr.valid = push_valid;
    ram_wr.addr  = wr_ptr[cdc_fifo_pkg::ADDR_W-1:0];
    ram_wr.data  = push_data;
  end

  // Gray copy moves on the same edge as the RAM write, so the pop side
  // never sees a pointer ahead of its data
  always_ff @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_next;
      wr_ptr_gray <= cdc_fifo_pkg::bin2gray(wr_ptr_next);
    end
  end

  // --------------------
  // Read pointer tracking
  // --------------------

  assign rd_ptr_bin = cdc_fifo_pkg::gray2bin(rd_ptr_gray_sync);
  // Entries freed by the pop side since last cycle, modulo pointer range
  assign rd_advance = rd_ptr_bin - rd_ptr_q;

  // Slots and full are measured against the registered read pointer,
  // the same one that feeds the credit counter
  assign occupancy  = wr_ptr - rd_ptr_q;
  assign push_slots = cdc_fifo_pkg::count_t'(cdc_fifo_pkg::DEPTH) - occupancy;
  assign push_full  = (occupancy == cdc_fifo_pkg::ptr_t'(cdc_fifo_pkg::DEPTH));

  // --------------------
  // Credit return
  // --------------------

  // Withheld credits stay in the counter, only the excess is offered
  assign credit_available = (credit_count > cfg.withhold) ?
                            credit_count - cfg.withhold : '0;

  // One pulse per cycle at most, stall blocks it in the same cycle
  assign push_credit = (credit_available != '0) && cfg.enable && !push_credit_stall;

  // Counter gives a credit away per pulse and gets one back per freed entry
  always_ff @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q     <= '0;
      credit_count <= cdc_cfg_pkg::credit_t'(cdc_fifo_pkg::DEPTH);
    end else begin
      rd_ptr_q     <= rd_ptr_bin;
      credit_count <= credit_count - cdc_cfg_pkg::credit_t'(push_credit)
                      + cdc_cfg_pkg::credit_t'(rd_advance);
    end
  end

endmodule

// File: logic/flop_ram.sv
// Dual clock flop RAM
`timescale 1ns/100ps

module flop_ram (
  input  logic                  push_clk,
  input  logic                  pop_clk,
  input  cdc_fifo_pkg::ram_wr_t wr,
  input  logic                  rd_en,
  input  cdc_fifo_pkg::addr_t   rd_addr,
  output cdc_fifo_pkg::data_t   rd_data
);

  // Storage array, one word per FIFO entry
  cdc_fifo_pkg::data_t mem [cdc_fifo_pkg::DEPTH];

  // Write port lives in the push domain
  always_ff @(posedge push_clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read port lives in the pop domain
  // The read register only loads on rd_en, so it keeps its word while
  // the consumer stalls and acts as the FIFO output register
  always_ff @(posedge pop_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: logic/gray_sync.sv
// Gray pointer synchronizer
`timescale 1ns/100ps

module gray_sync (
  input  logic               clk,
  input  logic               rst_n,
  input  cdc_fifo_pkg::ptr_t gray_in,
  output cdc_fifo_pkg::ptr_t gray_out
);

  // Stage 0 is the first flop to sample the foreign pointer and may go
  // metastable, later stages give it time to settle
  cdc_fifo_pkg::ptr_t [cdc_fifo_pkg::NUM_SYNC_STAGES-1:0] sync_q;

  // The source changes one bit per step, so any sampled value is either
  // the old or the new pointer and never a mix of the two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Gray code of zero is all zeros, matching the reset pointer
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[cdc_fifo_pkg::NUM_SYNC_STAGES-2:0], gray_in};
    end
  end

  // Last stage is the settled pointer in the destination domain
  assign gray_out = sync_q[cdc_fifo_pkg::NUM_SYNC_STAGES-1];

endmodule

// File: sim.f
logic/cdc_fifo_pkg.sv
logic/cdc_cfg_pkg.sv
logic/gray_sync.sv
logic/flop_ram.sv
logic/credit_cfg_regs.sv
logic/fifo_push_ctrl.sv
logic/fifo_pop_ctrl.sv
logic/cdc_fifo_top.sv
tb/cdc_fifo_tb.sv

// File: tb/cdc_fifo_tb.sv
// CDC FIFO testbench
`timescale 1ns/100ps

module cdc_fifo_tb;

  localparam int NUM_WORDS = 400;
  localparam int DEPTH = cdc_fifo_pkg::DEPTH;
  localparam int WITHHOLD = 3;
  // A word rarely needs more than a handful of push cycles, 50 leaves wide margin
  localparam int MAX_CYCLES = NUM_WORDS * 50;
  // Sync latency plus up to one credit pulse per entry
  localparam int SETTLE_CYCLES = 4 * DEPTH;
  localparam logic [31:0] SEED = 32'd17868;

  logic                   push_clk = 1'b0;
  logic                   pop_clk = 1'b0;
  logic                   rst_n = 1'b0;
  logic                   push_valid = 1'b0;
  cdc_fifo_pkg::data_t    push_data = '0;
  logic                   push_credit_stall = 1'b0;
  logic                   push_credit;
  logic                   push_full;
  cdc_fifo_pkg::count_t   push_slots;
  cdc_cfg_pkg::credit_t   credit_count;
  cdc_cfg_pkg::credit_t   credit_available;
  logic                   cfg_wr = 1'b0;
  cdc_cfg_pkg::cfg_addr_t cfg_addr = '0;
  cdc_cfg_pkg::credit_t   cfg_wdata = '0;
  logic                   pop_ready = 1'b0;
  logic                   pop_valid;
  cdc_fifo_pkg::data_t    pop_data;
  logic                   pop_empty;
  cdc_fifo_pkg::count_t   pop_items;

  // Sender model and scoreboard counters
  int credits_rcvd = 0;
  int sender_credits = 0;
  int pushed = 0;
  int popped = 0;
  int push_target = 0;
  int cycles = 0;
  logic stall_en = 1'b0;
  logic pop_hold = 1'b0;
  logic [31:0] push_rng = SEED;
  logic [31:0] pop_rng = ~SEED;
  // Pop output as seen on the previous pop edge
  logic prev_valid = 1'b0;
  logic prev_ready = 1'b0;
  cdc_fifo_pkg::data_t prev_data = '0;

  cdc_fifo_top cdc_fifo_top_i (
    .push_clk, .pop_clk, .rst_n, .push_valid, .push_data, .push_credit_stall,
    .push_credit, .push_full, .push_slots, .credit_count, .credit_available,
    .cfg_wr, .cfg_addr, .cfg_wdata, .pop_ready, .pop_valid, .pop_data,
    .pop_empty, .pop_items
  );

  // Unrelated periods keep the two clock phases drifting
  always #2 push_clk = ~push_clk;
  always #3.5 pop_clk = ~pop_clk;

  // --------------------
  // Helpers
  // --------------------

  // Scramble of the word index, so neighbouring words differ in many bits
  function automatic cdc_fifo_pkg::data_t expected_word(input int n);
    logic [31:0] x;
    x = n * 32'h0000_9e37 + 32'h0000_5a5a;
    return cdc_fifo_pkg::data_t'(x ^ (x >> 7));
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Stopped at the first failing check");
  endtask

  // One register write, visible to the push controller a cycle later
  task automatic write_cfg(input cdc_cfg_pkg::cfg_addr_t addr, input int value);
    @(posedge push_clk);
    #0.5;
    cfg_wr = 1'b1;
    cfg_addr = addr;
    cfg_wdata = cdc_cfg_pkg::credit_t'(value);
    @(posedge push_clk);
    #0.5;
    cfg_wr = 1'b0;
  endtask

  // Waits for every pushed word to leave, then for credits to come home
  task automatic drain_and_check(input int exp_credits);
    cdc_cfg_pkg::credit_t exp_count;
    int n;
    exp_count = cdc_cfg_pkg::credit_t'(DEPTH - exp_credits);
    n = 0;
    wait (popped == pushed);
    do begin
      @(posedge push_clk);
      n++;
    end while (!(push_slots == cdc_fifo_pkg::count_t'(DEPTH) && credit_count == exp_count
                 && !push_credit) && n < SETTLE_CYCLES);
    assert (pop_empty && pop_items == '0) else
      stop_on_error($sformatf("ERR pop_items: got %h expected 0, pop_empty %h",
                              pop_items, pop_empty));
    assert (push_slots == cdc_fifo_pkg::count_t'(DEPTH) && !push_full) else
      stop_on_error($sformatf("ERR push_slots: got %h expected %h, push_full %h",
                              push_slots, DEPTH, push_full));
    assert (credit_count == exp_count && credit_available == '0) else
      stop_on_error($sformatf("ERR credit_count: got %h expected %h, credit_available %h",
                              credit_count, exp_count, credit_available));
    assert (credits_rcvd - pushed == exp_credits) else
      stop_on_error($sformatf("ERR credits_rcvd-pushed: got %h expected %h",
                              credits_rcvd - pushed, exp_credits));
  endtask

  // --------------------
  // Sender model
  // --------------------

  // Control flags are taken at the edge so the drive below never races them
  always @(posedge push_clk) begin
    logic stall_ok;
    logic live;
    int target;
    stall_ok = stall_en;
    live = rst_n;
    target = push_target;
    if (live) begin
      assert (!(push_credit && push_credit_stall)) else
        stop_on_error("A credit pulse arrived while push_credit_stall was high");
      assert (push_slots <= cdc_fifo_pkg::count_t'(DEPTH)) else
        stop_on_error($sformatf("ERR push_slots: got %h above %h", push_slots, DEPTH));
      assert (!push_full || push_slots == '0) else
        stop_on_error($sformatf("ERR push_full: got %h with push_slots %h",
                                push_full, push_slots));
      if (push_credit) begin
        credits_rcvd++;
        sender_credits++;
      end
    end
    #0.5;
    push_rng = lcg_next(push_rng);
    push_valid = 1'b0;
    // Each push spends one credit that is already in hand
    if (live && sender_credits > 0 && pushed < target && push_rng[22:20] < 3'd5) begin
      push_valid = 1'b1;
      push_data = expected_word(pushed);
      pushed++;
      sender_credits--;
    end
    push_credit_stall = stall_ok && (push_rng[27:26] == 2'b00);
  end

  // --------------------
  // Pop checker
  // --------------------

  always @(posedge pop_clk) begin
    logic hold;
    hold = pop_hold;
    if (rst_n) begin
      // A stalled word has to sit still until it is taken
      if (prev_valid && !prev_ready) begin
        assert (pop_valid && pop_data == prev_data) else
          stop_on_error($sformatf("ERR pop_data: got %h expected %h under stall, pop_valid %h",
                                  pop_data, prev_data, pop_valid));
      end
      if (pop_valid && pop_ready) begin
        assert (popped < pushed) else
          stop_on_error("A word was popped that had never been pushed");
        assert (pop_data == expected_word(popped)) else
          stop_on_error($sformatf("ERR pop_data: got %h expected %h at word %0d",
                                  pop_data, expected_word(popped), popped));
        popped++;
      end
      assert (pop_items <= cdc_fifo_pkg::count_t'(DEPTH)) else
        stop_on_error($sformatf("ERR pop_items: got %h above %h", pop_items, DEPTH));
    end
    prev_valid = pop_valid;
    prev_ready = pop_ready;
    prev_data = pop_data;
    #0.5;
    pop_rng = lcg_next(pop_rng);
    pop_ready = !hold && (pop_rng[21:20] != 2'b00);
  end

  always @(posedge push_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      stop_on_error($sformatf("Run did not finish within %0d push cycles", MAX_CYCLES));
    end
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int n;
    repeat (8) @(posedge push_clk);
    #0.5;
    rst_n = 1'b1;

    // Nothing may flow while credits are disabled
    repeat (50) @(posedge push_clk);
    assert (credits_rcvd == 0) else
      stop_on_error("A credit pulse arrived before credits were enabled");

    // Main traffic with random gaps, stalls and back-pressure
    write_cfg(cdc_cfg_pkg::CFG_ADDR_ENABLE, 1);
    stall_en = 1'b1;
    push_target = NUM_WORDS;
    wait (pushed == NUM_WORDS);
    @(posedge push_clk);
    #0.5;
    stall_en = 1'b0;
    drain_and_check(DEPTH);

    // Sender spends all its credits into a blocked FIFO
    write_cfg(cdc_cfg_pkg::CFG_ADDR_WITHHOLD, WITHHOLD);
    pop_hold = 1'b1;
    push_target = NUM_WORDS + DEPTH;
    wait (pushed == push_target);
    // The oldest word moves into the output register and frees one slot,
    // which stays below the withhold and so returns no credit
    n = 0;
    do begin
      @(posedge push_clk);
      n++;
    end while (push_slots != cdc_fifo_pkg::count_t'(1) && n < SETTLE_CYCLES);
    assert (push_slots == cdc_fifo_pkg::count_t'(1) && !push_full && !push_credit) else
      stop_on_error($sformatf("ERR push_slots: got %h expected 1, push_full %h",
                              push_slots, push_full));
    #0.5;
    pop_hold = 1'b0;
    // Withheld credits stay behind in the receiver count
    drain_and_check(DEPTH - WITHHOLD);

    $display("Finished with no errors");
    $finish;
  end

endmodule
